//--- filelist.f
+incdir+src
src/int_pipe_pkg.sv
src/issue_if.sv
src/int_alu.sv
src/issue_decode.sv
src/issue_queue.sv
src/pipe_int.sv
src/int_pipe_top.sv
test/tb_clock_gen.sv
test/tb_int_pipe.sv

//--- run.sh
#!/bin/sh
# Build and run the integer pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module tb_int_pipe -o tb_int_pipe

./obj_dir/tb_int_pipe | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

//--- src/int_alu.sv
/* Integer ALU
   Arithmetic, logic, shift and compare on two operands */

`timescale 1ns/10ps
`include "int_pipe_defs.svh"

module int_alu (
   input  logic [`INT_PIPE_XLEN-1:0] src1_i,
   input  logic [`INT_PIPE_XLEN-1:0] src2_i,
   input  int_pipe_pkg::int_op_e     op_i,
   output logic [`INT_PIPE_XLEN-1:0] result_o
);
   import int_pipe_pkg::*;

   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;
   logic       eq;

   assign shamt = src2_i[4:0];
   assign lt_s  = $signed(src1_i) < $signed(src2_i);
   assign lt_u  = src1_i < src2_i;
   assign eq    = src1_i == src2_i;

   always_comb
   begin
      case (op_i)
         op_add:  result_o = src1_i + src2_i;
         op_sub:  result_o = src1_i - src2_i;
         op_sll:  result_o = src1_i << shamt;
         op_srl:  result_o = src1_i >> shamt;
         op_sra:  result_o = $unsigned($signed(src1_i) >>> shamt);
         op_xor:  result_o = src1_i ^ src2_i;
         op_or:   result_o = src1_i | src2_i;
         op_and:  result_o = src1_i & src2_i;
         // Flag only, upper bits zero
         op_slt:  result_o = `INT_PIPE_XLEN'(lt_s);
         op_sltu: result_o = `INT_PIPE_XLEN'(lt_u);
         op_eq:   result_o = `INT_PIPE_XLEN'(eq);
         op_ne:   result_o = `INT_PIPE_XLEN'(!eq);
         op_lt:   result_o = `INT_PIPE_XLEN'(lt_s);
         op_ge:   result_o = `INT_PIPE_XLEN'(!lt_s);
         op_ltu:  result_o = `INT_PIPE_XLEN'(lt_u);
         default: result_o = `INT_PIPE_XLEN'(!lt_u);
      endcase
   end

endmodule

//--- src/int_pipe_defs.svh
/* Integer pipe parameters
   Data width and default issue queue depth */

`ifndef INT_PIPE_DEFS_SVH
`define INT_PIPE_DEFS_SVH

// Width of data, operands and PC
`define INT_PIPE_XLEN 32

// Default number of issue queue entries
`define INT_PIPE_QDEPTH 4

`endif

//--- src/int_pipe_pkg.sv
/* Integer pipe types
   ALU operations, decoded control word and RV32 instruction formats */

package int_pipe_pkg;

   // RV32 base opcodes handled by the pipe
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;

   // Compare ops return their flag in bit 0
   typedef enum logic [3:0] {
      op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra,
      op_or, op_and, op_eq, op_ne, op_lt, op_ge, op_ltu, op_geu
   } int_op_e;

   typedef struct packed {
      int_op_e fu_op;
      logic    src1_sel;   // PC in place of rs1
      logic    src2_sel;   // Immediate in place of rs2
      logic    baddr_sel;  // rs1 as branch base
      logic    result_sel; // Data is PC+4
      logic    br_v;
      logic    jmp_v;
      logic    illegal;
   } int_decode_s;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv_r_s;

   typedef struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } rv_i_s;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } rv_b_s;

   // Upper bits also serve as the U immediate
   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv_j_s;

   typedef union packed {
      rv_r_s r;
      rv_i_s i;
      rv_b_s b;
      rv_j_s j;
   } rv_instr_u;

endpackage

//--- src/int_pipe_top.sv
/* Integer execute subsystem
   Decoder, issue queue and integer pipe in series */

`timescale 1ns/10ps
`include "int_pipe_defs.svh"

module int_pipe_top (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      instr_valid_i,
   output logic                      instr_ready_o,
   input  logic [31:0]               instr_i,
   input  logic [`INT_PIPE_XLEN-1:0] pc_i,
   input  logic [`INT_PIPE_XLEN-1:0] rs1_i,
   input  logic [`INT_PIPE_XLEN-1:0] rs2_i,
   input  logic                      res_ready_i,
   output logic                      res_valid_o,
   output logic [`INT_PIPE_XLEN-1:0] res_data_o,
   output logic [`INT_PIPE_XLEN-1:0] res_br_tgt_o,
   output logic                      res_btaken_o,
   output logic                      res_illegal_o
);

   issue_if q_in ();
   issue_if q_out ();

   issue_decode u_issue_decode (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .instr_valid_i (instr_valid_i),
      .instr_ready_o (instr_ready_o),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .rs1_i         (rs1_i),
      .rs2_i         (rs2_i),
      .issue_o       (q_in.src)
   );

   issue_queue #(
      .depth_p (`INT_PIPE_QDEPTH)
   ) u_issue_queue (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .enq_i   (q_in.dst),
      .deq_o   (q_out.src)
   );

   pipe_int u_pipe_int (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .issue_i       (q_out.dst),
      .res_ready_i   (res_ready_i),
      .res_valid_o   (res_valid_o),
      .res_data_o    (res_data_o),
      .res_br_tgt_o  (res_br_tgt_o),
      .res_btaken_o  (res_btaken_o),
      .res_illegal_o (res_illegal_o)
   );

endmodule

//--- src/issue_decode.sv
/* Issue decoder
   Registers incoming instructions as decoded operations with immediates */

`timescale 1ns/10ps
`include "int_pipe_defs.svh"

module issue_decode (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      instr_valid_i,
   output logic                      instr_ready_o,
   input  logic [31:0]               instr_i,
   input  logic [`INT_PIPE_XLEN-1:0] pc_i,
   input  logic [`INT_PIPE_XLEN-1:0] rs1_i,
   input  logic [`INT_PIPE_XLEN-1:0] rs2_i,
   issue_if.src                      issue_o
);
   import int_pipe_pkg::*;

   function automatic int_op_e alu_op(input logic [2:0] funct3, input logic alt);
      int_op_e op;
      case (funct3)
         3'b000:  op = alt ? op_sub : op_add;
         3'b001:  op = op_sll;
         3'b010:  op = op_slt;
         3'b011:  op = op_sltu;
         3'b100:  op = op_xor;
         3'b101:  op = alt ? op_sra : op_srl;
         3'b110:  op = op_or;
         default: op = op_and;
      endcase
      return op;
   endfunction

   rv_instr_u                  instr;
   int_decode_s                dec;
   logic [`INT_PIPE_XLEN-1:0]  imm;
   logic                       alt;

   logic                       valid_q;
   int_decode_s                decode_q;
   logic [`INT_PIPE_XLEN-1:0]  pc_q;
   logic [`INT_PIPE_XLEN-1:0]  rs1_q;
   logic [`INT_PIPE_XLEN-1:0]  rs2_q;
   logic [`INT_PIPE_XLEN-1:0]  imm_q;

   assign instr = instr_i;

   // Bit 30 selects SUB only for register ops, SRA for both
   assign alt = instr.r.funct7[5]
                & ((instr.r.opcode == opc_op) | (instr.r.funct3 == 3'b101));

   always_comb
   begin
      dec       = '0;
      dec.fu_op = op_add;
      imm       = '0;
      case (instr.r.opcode)
         opc_op:
            dec.fu_op = alu_op(instr.r.funct3, alt);
         opc_op_imm:
         begin
            dec.fu_op    = alu_op(instr.i.funct3, alt);
            dec.src2_sel = 1'b1;
            imm = {{(`INT_PIPE_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
         end
         opc_auipc:
         begin
            dec.src1_sel = 1'b1;
            dec.src2_sel = 1'b1;
            imm = {instr.j.imm_20, instr.j.imm_10_1, instr.j.imm_11,
                   instr.j.imm_19_12, 12'b0};
         end
         opc_jal:
         begin
            dec.jmp_v      = 1'b1;
            dec.result_sel = 1'b1;
            imm = {{(`INT_PIPE_XLEN-21){instr.j.imm_20}}, instr.j.imm_20,
                   instr.j.imm_19_12, instr.j.imm_11, instr.j.imm_10_1, 1'b0};
         end
         opc_jalr:
         begin
            dec.jmp_v      = 1'b1;
            dec.result_sel = 1'b1;
            dec.baddr_sel  = 1'b1;
            imm = {{(`INT_PIPE_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
         end
         opc_branch:
         begin
            dec.br_v = 1'b1;
            imm = {{(`INT_PIPE_XLEN-13){instr.b.imm_12}}, instr.b.imm_12,
                   instr.b.imm_11, instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            case (instr.b.funct3)
               3'b000:  dec.fu_op = op_eq;
               3'b001:  dec.fu_op = op_ne;
               3'b100:  dec.fu_op = op_lt;
               3'b101:  dec.fu_op = op_ge;
               3'b110:  dec.fu_op = op_ltu;
               3'b111:  dec.fu_op = op_geu;
               default: dec.illegal = 1'b1;
            endcase
         end
         default:
            dec.illegal = 1'b1;
      endcase
   end

   // Free slot, or the held operation leaves this cycle
   assign instr_ready_o = ~valid_q | issue_o.ready;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         valid_q <= 1'b0;
      else if (instr_ready_o)
         valid_q <= instr_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (instr_valid_i && instr_ready_o)
      begin
         decode_q <= dec;
         pc_q     <= pc_i;
         rs1_q    <= rs1_i;
         rs2_q    <= rs2_i;
         imm_q    <= imm;
      end
   end

   assign issue_o.valid  = valid_q;
   assign issue_o.decode = decode_q;
   assign issue_o.pc     = pc_q;
   assign issue_o.rs1    = rs1_q;
   assign issue_o.rs2    = rs2_q;
   assign issue_o.imm    = imm_q;

   // A stalled instruction at the input stays in place until taken
   ap_instr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      instr_valid_i && !instr_ready_o |=> instr_valid_i
         && $stable({instr_i, pc_i, rs1_i, rs2_i}));

endmodule

//--- src/issue_if.sv
/* Issue channel
   One decoded operation with its operands under valid/ready */

`timescale 1ns/10ps
`include "int_pipe_defs.svh"

interface issue_if;
   import int_pipe_pkg::*;

   logic                       valid;
   logic                       ready;
   int_decode_s                decode;
   logic [`INT_PIPE_XLEN-1:0]  pc;
   logic [`INT_PIPE_XLEN-1:0]  rs1;
   logic [`INT_PIPE_XLEN-1:0]  rs2;
   logic [`INT_PIPE_XLEN-1:0]  imm;

   // Sending side
   modport src (
      output valid, decode, pc, rs1, rs2, imm,
      input  ready
   );

   // Receiving side
   modport dst (
      input  valid, decode, pc, rs1, rs2, imm,
      output ready
   );

endinterface

//--- src/issue_queue.sv
/* Issue queue
   Circular buffer of decoded operations between decoder and integer pipe */

`timescale 1ns/10ps
`include "int_pipe_defs.svh"

module issue_queue #(
   parameter int depth_p = `INT_PIPE_QDEPTH
) (
   input  logic clk_i,
   input  logic rst_n_i,
   issue_if.dst enq_i,
   issue_if.src deq_o
);
   import int_pipe_pkg::*;

   localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int cnt_w_lp = $clog2(depth_p + 1);

   int_decode_s               decode_mem [depth_p];
   logic [`INT_PIPE_XLEN-1:0] pc_mem     [depth_p];
   logic [`INT_PIPE_XLEN-1:0] rs1_mem    [depth_p];
   logic [`INT_PIPE_XLEN-1:0] rs2_mem    [depth_p];
   logic [`INT_PIPE_XLEN-1:0] imm_mem    [depth_p];

   logic [ptr_w_lp-1:0] wr_ptr_q;
   logic [ptr_w_lp-1:0] rd_ptr_q;
   logic [cnt_w_lp-1:0] count_q;
   logic                enq_fire;
   logic                deq_fire;

   assign enq_i.ready = (count_q != cnt_w_lp'(depth_p));
   assign deq_o.valid = (count_q != '0);
   assign enq_fire    = enq_i.valid & enq_i.ready;
   assign deq_fire    = deq_o.valid & deq_o.ready;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (enq_fire)
            wr_ptr_q <= (wr_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (deq_fire)
            rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (enq_fire && !deq_fire)
            count_q <= count_q + 1'b1;
         else if (!enq_fire && deq_fire)
            count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq_fire)
      begin
         decode_mem[wr_ptr_q] <= enq_i.decode;
         pc_mem[wr_ptr_q]     <= enq_i.pc;
         rs1_mem[wr_ptr_q]    <= enq_i.rs1;
         rs2_mem[wr_ptr_q]    <= enq_i.rs2;
         imm_mem[wr_ptr_q]    <= enq_i.imm;
      end
   end

   // Head entry read straight from the array
   assign deq_o.decode = decode_mem[rd_ptr_q];
   assign deq_o.pc     = pc_mem[rd_ptr_q];
   assign deq_o.rs1    = rs1_mem[rd_ptr_q];
   assign deq_o.rs2    = rs2_mem[rd_ptr_q];
   assign deq_o.imm    = imm_mem[rd_ptr_q];

   // Decoder keeps a stalled operation in place until it is written
   ap_enq_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      enq_i.valid && !enq_i.ready |=> enq_i.valid
         && $stable({enq_i.decode, enq_i.pc, enq_i.rs1, enq_i.rs2, enq_i.imm}));

endmodule

//--- src/pipe_int.sv
/* Integer pipe
   Computes data, branch target and taken flag into a result register */

`timescale 1ns/10ps
`include "int_pipe_defs.svh"

module pipe_int (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   issue_if.dst                      issue_i,
   input  logic                      res_ready_i,
   output logic                      res_valid_o,
   output logic [`INT_PIPE_XLEN-1:0] res_data_o,
   output logic [`INT_PIPE_XLEN-1:0] res_br_tgt_o,
   output logic                      res_btaken_o,
   output logic                      res_illegal_o
);
   import int_pipe_pkg::*;

   int_decode_s               decode;
   logic [`INT_PIPE_XLEN-1:0] src1;
   logic [`INT_PIPE_XLEN-1:0] src2;
   logic [`INT_PIPE_XLEN-1:0] baddr;
   logic [`INT_PIPE_XLEN-1:0] pc_plus4;
   logic [`INT_PIPE_XLEN-1:0] alu_result;
   logic [`INT_PIPE_XLEN-1:0] data;
   logic [`INT_PIPE_XLEN-1:0] br_tgt;
   logic                      btaken;
   logic                      load;

   assign decode = issue_i.decode;

   int_alu u_int_alu (
      .src1_i   (src1),
      .src2_i   (src2),
      .op_i     (decode.fu_op),
      .result_o (alu_result)
   );

   always_comb
   begin
      src1     = decode.src1_sel  ? issue_i.pc  : issue_i.rs1;
      src2     = decode.src2_sel  ? issue_i.imm : issue_i.rs2;
      baddr    = decode.baddr_sel ? issue_i.rs1 : issue_i.pc;
      pc_plus4 = issue_i.pc + `INT_PIPE_XLEN'(4);
      btaken   = ((decode.br_v & alu_result[0]) | decode.jmp_v) & ~decode.illegal;
      br_tgt   = btaken ? baddr + issue_i.imm : pc_plus4;
      if (decode.illegal)
         data = '0;
      else
         data = decode.result_sel ? pc_plus4 : alu_result;
   end

   // Result register empty, or its content drains this cycle
   assign issue_i.ready = ~res_valid_o | res_ready_i;
   assign load          = issue_i.valid & issue_i.ready;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         res_valid_o <= 1'b0;
      else if (issue_i.ready)
         res_valid_o <= issue_i.valid;
   end

   always_ff @(posedge clk_i)
   begin
      if (load)
      begin
         res_data_o    <= data;
         res_br_tgt_o  <= br_tgt;
         res_btaken_o  <= btaken;
         res_illegal_o <= decode.illegal;
      end
   end

   // Queue head must not move while the pipe is stalled
   ap_issue_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      issue_i.valid && !issue_i.ready |=> issue_i.valid
         && $stable({issue_i.decode, issue_i.pc, issue_i.rs1, issue_i.rs2, issue_i.imm}));

endmodule

//--- test/tb_clock_gen.sv
/* Testbench clock source
   Free-running clock with a fixed period */

`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int period_p = 20
) (
   output logic clk_o
);

   initial
   begin
      clk_o = 1'b0;
   end

   always #(period_p / 2) clk_o = ~clk_o;

endmodule

//--- test/tb_int_pipe.sv
/* Integer pipe testbench
   Random instructions checked in order against a reference model */

`timescale 1ns/10ps
`include "int_pipe_defs.svh"

module tb_int_pipe;

   localparam int num_instr_lp  = 150;
   localparam int num_tests_lp  = 6;
   localparam int max_cycles_lp = num_tests_lp * num_instr_lp * 8 + 1000;

   typedef logic [`INT_PIPE_XLEN-1:0] word_t;

   typedef struct packed {
      logic [31:0] instr;
      word_t       data;
      word_t       tgt;
      logic        taken;
      logic        illegal;
   } exp_s;

   logic        clk;
   logic        rst_n;
   logic        instr_valid;
   logic        instr_ready;
   logic [31:0] instr;
   word_t       pc;
   word_t       rs1;
   word_t       rs2;
   logic        res_ready;
   logic        res_valid;
   word_t       res_data;
   word_t       res_tgt;
   logic        res_taken;
   logic        res_illegal;

   logic [31:0] lfsr_q = 32'hdc27;
   exp_s        exp_q[$];
   int          acc_q[$];
   int          cycle = 0;
   int          err_count = 0;
   int          pass_tests = 0;
   int          fail_tests = 0;
   bit          check_latency = 1'b0;

   tb_clock_gen #(.period_p(20)) u_tb_clock_gen (.clk_o(clk));

   int_pipe_top u_int_pipe_top (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .instr_valid_i (instr_valid),
      .instr_ready_o (instr_ready),
      .instr_i       (instr),
      .pc_i          (pc),
      .rs1_i         (rs1),
      .rs2_i         (rs2),
      .res_ready_i   (res_ready),
      .res_valid_o   (res_valid),
      .res_data_o    (res_data),
      .res_br_tgt_o  (res_tgt),
      .res_btaken_o  (res_taken),
      .res_illegal_o (res_illegal)
   );

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
      return val;
   endfunction

   // RV32I ALU semantics by funct3, alt picks SUB or SRA
   function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << b[4:0];
         3'b010:  return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
         3'b011:  return (a < b) ? word_t'(1) : word_t'(0);
         3'b100:  return a ^ b;
         3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic exp_s expect_result(input logic [31:0] ins, input word_t pc_v,
                                          input word_t rs1_v, input word_t rs2_v);
      exp_s       e;
      word_t      imm_i;
      word_t      imm_b;
      word_t      imm_j;
      word_t      imm_u;
      word_t      pc4;
      logic [2:0] f3;
      logic       cond;
      f3    = ins[14:12];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      imm_u = {ins[31:12], 12'b0};
      pc4   = pc_v + 32'd4;
      cond  = 1'b0;
      e     = '0;
      e.instr = ins;
      e.tgt   = pc4;
      case (ins[6:0])
         7'b0110011: e.data = alu_ref(f3, ins[30], rs1_v, rs2_v);
         7'b0010011: e.data = alu_ref(f3, ins[30] && f3 == 3'b101, rs1_v, imm_i);
         7'b0010111: e.data = pc_v + imm_u;
         7'b1101111:
         begin
            e.data  = pc4;
            e.taken = 1'b1;
            e.tgt   = pc_v + imm_j;
         end
         7'b1100111:
         begin
            e.data  = pc4;
            e.taken = 1'b1;
            e.tgt   = rs1_v + imm_i;
         end
         7'b1100011:
         begin
            case (f3)
               3'b000:  cond = rs1_v == rs2_v;
               3'b001:  cond = rs1_v != rs2_v;
               3'b100:  cond = $signed(rs1_v) < $signed(rs2_v);
               3'b101:  cond = $signed(rs1_v) >= $signed(rs2_v);
               3'b110:  cond = rs1_v < rs2_v;
               3'b111:  cond = rs1_v >= rs2_v;
               default: e.illegal = 1'b1;
            endcase
            if (!e.illegal)
            begin
               e.data  = word_t'(cond);
               e.taken = cond;
               if (cond)
                  e.tgt = pc_v + imm_b;
            end
         end
         default: e.illegal = 1'b1;
      endcase
      return e;
   endfunction

   function automatic logic [31:0] gen_r();
      logic [2:0] f3;
      logic       alt;
      logic [9:0] regs;
      logic [4:0] rd;
      f3   = 3'(rand_bits(3));
      alt  = (f3 == 3'b000 || f3 == 3'b101) && (rand_bits(1) != 0);
      regs = 10'(rand_bits(10));
      rd   = 5'(rand_bits(5));
      return {1'b0, alt, 5'b0, regs, f3, rd, 7'b0110011};
   endfunction

   // Immediate ALU ops plus an occasional AUIPC
   function automatic logic [31:0] gen_i();
      logic [2:0]  sel;
      logic [2:0]  f3;
      logic [11:0] imm;
      logic [19:0] upper;
      logic [4:0]  rs1f;
      logic [4:0]  rd;
      sel   = 3'(rand_bits(3));
      upper = 20'(rand_bits(20));
      rd    = 5'(rand_bits(5));
      if (sel == 3'd7)
         return {upper, rd, 7'b0010111};
      f3   = 3'(rand_bits(3));
      imm  = upper[19:8];
      rs1f = upper[7:3];
      if (f3 == 3'b001)
         imm[11:5] = 7'b0;
      else if (f3 == 3'b101)
         imm[11:5] = {1'b0, imm[10], 5'b0};
      return {imm, rs1f, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] gen_branch();
      logic [2:0]  f3;
      logic [12:1] off;
      logic [9:0]  regs;
      f3   = 3'(rand_bits(3));
      off  = 12'(rand_bits(12));
      regs = 10'(rand_bits(10));
      // Fold the two reserved encodings onto BLT and BLTU
      if (f3 == 3'b010 || f3 == 3'b011)
         f3 = {1'b1, f3[0], 1'b0};
      return {off[12], off[10:5], regs, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] gen_jump();
      logic [19:0] upper;
      logic [4:0]  rd;
      upper = 20'(rand_bits(20));
      rd    = 5'(rand_bits(5));
      if (rand_bits(1) != 0)
         return {upper, rd, 7'b1101111};
      return {upper[19:8], upper[7:3], 3'b000, rd, 7'b1100111};
   endfunction

   function automatic logic [31:0] gen_illegal();
      logic [24:0] body;
      logic [6:0]  opc;
      body = 25'(rand_bits(25));
      if (rand_bits(2) == 0)
      begin
         body[7:6] = 2'b01;
         return {body, 7'b1100011};
      end
      opc = 7'(rand_bits(7));
      while (opc inside {7'b0110011, 7'b0010011, 7'b0010111, 7'b1100011,
                         7'b1101111, 7'b1100111})
         opc = 7'(rand_bits(7));
      return {body, opc};
   endfunction

   task automatic load_instr(input int kind);
      int k;
      k = kind;
      if (k == 5)
         k = int'(rand_bits(3)) % 5;
      pc  = rand_bits(30) << 2;
      rs1 = rand_bits(32);
      // Branches see equal operands about a quarter of the time
      if (k == 2 && rand_bits(2) == 0)
         rs2 = rs1;
      else
         rs2 = rand_bits(32);
      case (k)
         0:       instr = gen_r();
         1:       instr = gen_i();
         2:       instr = gen_branch();
         3:       instr = gen_jump();
         default: instr = gen_illegal();
      endcase
      instr_valid = 1'b1;
   endtask

   task automatic check_result();
      exp_s e;
      int   acc;
      if (exp_q.size() == 0)
      begin
         $display("Result appeared at cycle %0d with no instruction in flight", cycle);
         err_count++;
      end
      else
      begin
         e   = exp_q.pop_front();
         acc = acc_q.pop_front();
         if (res_data !== e.data)
         begin
            $display("Error: res_data_o expected %h got %h (instr %h)", e.data, res_data, e.instr);
            err_count++;
         end
         if (res_tgt !== e.tgt)
         begin
            $display("Error: res_br_tgt_o expected %h got %h (instr %h)", e.tgt, res_tgt, e.instr);
            err_count++;
         end
         if (res_taken !== e.taken)
         begin
            $display("Error: res_btaken_o expected %h got %h (instr %h)", e.taken, res_taken,
                     e.instr);
            err_count++;
         end
         if (res_illegal !== e.illegal)
         begin
            $display("Error: res_illegal_o expected %h got %h (instr %h)", e.illegal, res_illegal,
                     e.instr);
            err_count++;
         end
         if (check_latency && (cycle - acc) != 3)
         begin
            $display("Result of instr %h took %0d cycles instead of 3", e.instr, cycle - acc);
            err_count++;
         end
      end
   endtask

   task automatic run_test(input int kind, input string name, input bit bp);
      int sent;
      int err_start;
      bit accepted;
      sent          = 0;
      accepted      = 1'b0;
      err_start     = err_count;
      check_latency = !bp;
      while (sent < num_instr_lp)
      begin
         @(negedge clk);
         res_ready = bp ? (rand_bits(1) != 0) : 1'b1;
         if (!instr_valid || accepted)
         begin
            if (!bp || rand_bits(2) != 0)
               load_instr(kind);
            else
               instr_valid = 1'b0;
         end
         @(posedge clk);
         accepted = instr_valid && instr_ready;
         if (accepted)
            sent++;
      end
      @(negedge clk);
      instr_valid = 1'b0;
      res_ready   = 1'b1;
      while (exp_q.size() != 0)
         @(negedge clk);
      if (err_count == err_start)
      begin
         pass_tests++;
         $display("Test %s: %0d instructions, passed", name, num_instr_lp);
      end
      else
      begin
         fail_tests++;
         $display("Test %s: %0d instructions, failed with %0d errors", name, num_instr_lp,
                  err_count - err_start);
      end
   endtask

   // Model sees each accepted input, checker sees each result transfer
   always @(posedge clk)
   begin
      if (rst_n && instr_valid && instr_ready)
      begin
         exp_q.push_back(expect_result(instr, pc, rs1, rs2));
         acc_q.push_back(cycle);
      end
      if (rst_n && res_valid && res_ready)
         check_result();
   end

   always @(negedge clk)
   begin
      cycle++;
      if (cycle > max_cycles_lp)
      begin
         $display("Timeout: run did not finish within %0d cycles", max_cycles_lp);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial
   begin
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      pc          = '0;
      rs1         = '0;
      rs2         = '0;
      res_ready   = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      if (instr_ready !== 1'b1)
      begin
         $display("Error: instr_ready_o expected %h got %h after reset", 1'b1, instr_ready);
         err_count++;
      end
      if (res_valid !== 1'b0)
      begin
         $display("Error: res_valid_o expected %h got %h after reset", 1'b0, res_valid);
         err_count++;
      end
      run_test(0, "r_type", 1'b0);
      run_test(1, "i_type_auipc", 1'b0);
      run_test(2, "branch", 1'b0);
      run_test(3, "jump", 1'b0);
      run_test(4, "illegal", 1'b0);
      run_test(5, "mixed_backpressure", 1'b1);
      $display("Tests: %0d passed, %0d failed", pass_tests, fail_tests);
      if (fail_tests == 0 && err_count == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
